// File: hw/chol_consts.svh
`ifndef CHOL_CONSTS_SVH
`define CHOL_CONSTS_SVH

// ========================================================
// Fixed-point format
// ========================================================

`define CHOL_W          32  // Bits per matrix element
`define CHOL_FRAC       16  // Fraction bits

// ========================================================
// Matrix geometry
// ========================================================

`define CHOL_N          3   // Matrix order
`define CHOL_ENTRIES    6   // Lower triangle entries, N*(N+1)/2

// ========================================================
// Arithmetic unit iteration counts
// ========================================================

`define CHOL_SQRT_ITER  24  // One root bit per cycle, (W+FRAC)/2
`define CHOL_DIV_ITER   48  // One quotient bit per cycle, W+FRAC

`endif

// File: hw/chol_fixed_pkg.sv
`include "chol_consts.svh"

// ========================================================
// Fixed-point numeric types
// ========================================================

package chol_fixed_pkg;

    // Signed element with CHOL_FRAC fraction bits
    typedef logic signed [`CHOL_W-1:0] fixed_t;

    // Full product of two elements before rescaling
    typedef logic signed [2*`CHOL_W-1:0] wide_t;

endpackage

// File: hw/chol_matrix_pkg.sv
`include "chol_consts.svh"

// ========================================================
// Lower-triangle matrix storage
// ========================================================

package chol_matrix_pkg;

    import chol_fixed_pkg::*;

    // Entries in row order 11, 21, 22, 31, 32, 33
    typedef fixed_t [`CHOL_ENTRIES-1:0] tri_mat_t;

    typedef logic [$clog2(`CHOL_ENTRIES)-1:0] entry_idx_t;  // Slot in tri_mat_t
    typedef logic [$clog2(`CHOL_N)-1:0] pos_t;              // Row or column number

    // Packed slot of element (row, col) with col <= row, both zero based
    function automatic entry_idx_t tri_idx(input pos_t row, input pos_t col);
        int r;
        r = int'(row);
        return entry_idx_t'(r * (r + 1) / 2 + int'(col));
    endfunction

endpackage

// File: hw/chol_arith_if.sv
`timescale 1ns/1ps

// ========================================================
// One operation to an arithmetic unit and its result
// ========================================================

interface chol_arith_if ();

    import chol_fixed_pkg::*;

    logic   start;      // One-cycle pulse, unit must be idle
    fixed_t operand_a;  // Radicand or dividend
    fixed_t operand_b;  // Divisor, unused by the square root
    fixed_t result;     // Valid while done is high
    logic   done;       // One-cycle pulse

    modport master (
        output start,
        output operand_a,
        output operand_b,
        input  result,
        input  done
    );

    modport unit (
        input  start,
        input  operand_a,
        input  operand_b,
        output result,
        output done
    );

endinterface

// File: hw/chol_sqrt_unit.sv
`timescale 1ns/1ps
`include "chol_consts.svh"

module chol_sqrt_unit (
    input logic        clk,
    input logic        rst,
    chol_arith_if.unit bus
);

    import chol_fixed_pkg::*;

    localparam int ITER = `CHOL_SQRT_ITER;
    localparam int RW   = ITER + 6;         // Remainder with headroom for 4r + 4q + 3
    localparam int CW   = $clog2(ITER);

    logic                 active;
    logic [CW-1:0]        cnt;
    logic [2*ITER-1:0]    rad;              // Radicand, leading pair consumed each step
    logic [ITER-1:0]      root;
    logic signed [RW-1:0] rem;
    logic signed [RW-1:0] trial;
    logic signed [RW-1:0] q_term;
    logic signed [RW-1:0] rem_next;

    // Non-restoring step, add back when the remainder went negative
    assign trial    = {rem[RW-3:0], rad[2*ITER-1 -: 2]};
    assign q_term   = {{(RW-ITER-2){1'b0}}, root, (rem[RW-1] ? 2'b11 : 2'b01)};
    assign rem_next = rem[RW-1] ? trial + q_term : trial - q_term;

    assign bus.result = fixed_t'(root);     // Zero extended, root is never negative

    always_ff @(posedge clk) begin
        if (rst) begin
            active   <= 1'b0;
            cnt      <= '0;
            bus.done <= 1'b0;
        end else begin
            bus.done <= 1'b0;
            if (bus.start && !active) begin
                active <= 1'b1;
                cnt    <= '0;
            end else if (active) begin
                cnt <= cnt + 1'b1;
                if (cnt == CW'(ITER - 1)) begin
                    active   <= 1'b0;
                    bus.done <= 1'b1;   // Last root bit lands on this edge
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.start && !active) begin
            rad  <= {bus.operand_a, {`CHOL_FRAC{1'b0}}};  // Scale so the root keeps FRAC bits
            rem  <= '0;
            root <= '0;
        end else if (active) begin
            rad  <= rad << 2;
            rem  <= rem_next;
            root <= {root[ITER-2:0], ~rem_next[RW-1]};
        end
    end

    // Sequencer must hand over a non-negative residual to an idle unit
    a_start_ok: assert property (@(posedge clk) disable iff (rst)
        bus.start |-> (!bus.operand_a[`CHOL_W-1] && !active))
        else $error("sqrt start with negative radicand or while busy");

endmodule

// File: hw/chol_div_unit.sv
`timescale 1ns/1ps
`include "chol_consts.svh"

module chol_div_unit (
    input logic        clk,
    input logic        rst,
    chol_arith_if.unit bus
);

    import chol_fixed_pkg::*;

    localparam int W    = `CHOL_W;
    localparam int ITER = `CHOL_DIV_ITER;
    localparam int CW   = $clog2(ITER);

    logic          active;
    logic          neg;         // Quotient sign
    logic [CW-1:0] cnt;
    logic [ITER-1:0] num;       // Dividend magnitude shifts out, quotient shifts in
    logic [W-1:0]  dvs;         // Divisor magnitude
    logic [W-1:0]  rem;
    logic [W:0]    rem_sh;
    logic [W:0]    diff;
    logic [W-1:0]  a_mag;
    logic [W-1:0]  b_mag;
    fixed_t        quot;

    assign a_mag = bus.operand_a[W-1] ? -bus.operand_a : bus.operand_a;
    assign b_mag = bus.operand_b[W-1] ? -bus.operand_b : bus.operand_b;

    // Restoring step, keep the difference only when it is not negative
    assign rem_sh = {rem, num[ITER-1]};
    assign diff   = rem_sh - {1'b0, dvs};

    assign quot       = fixed_t'(num[W-1:0]);   // Low word of the quotient
    assign bus.result = neg ? -quot : quot;

    always_ff @(posedge clk) begin
        if (rst) begin
            active   <= 1'b0;
            cnt      <= '0;
            bus.done <= 1'b0;
        end else begin
            bus.done <= 1'b0;
            if (bus.start && !active) begin
                active <= 1'b1;
                cnt    <= '0;
            end else if (active) begin
                cnt <= cnt + 1'b1;
                if (cnt == CW'(ITER - 1)) begin
                    active   <= 1'b0;
                    bus.done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.start && !active) begin
            num <= {a_mag, {`CHOL_FRAC{1'b0}}};
            dvs <= b_mag;
            rem <= '0;
            neg <= bus.operand_a[W-1] ^ bus.operand_b[W-1];
        end else if (active) begin
            rem <= diff[W] ? rem_sh[W-1:0] : diff[W-1:0];
            num <= {num[ITER-2:0], ~diff[W]};
        end
    end

    // Divisor is an L diagonal already produced, never zero in a valid run
    a_start_ok: assert property (@(posedge clk) disable iff (rst)
        bus.start |-> ((bus.operand_b != '0) && !active))
        else $error("divider start with zero divisor or while busy");

endmodule

// File: hw/chol_sequencer.sv
`timescale 1ns/1ps
`include "chol_consts.svh"

module chol_sequencer (
    input  logic                      clk,
    input  logic                      rst,
    input  chol_matrix_pkg::tri_mat_t a_in,
    input  logic                      a_valid,
    output chol_matrix_pkg::tri_mat_t l_out,
    output logic                      l_valid,
    output logic                      busy,
    chol_arith_if.master              sqrt_bus,
    chol_arith_if.master              div_bus
);

    import chol_fixed_pkg::*;
    import chol_matrix_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,         // Waiting for a_valid
        S_TERM,         // One product term per cycle, then issue
        S_SQRT_WAIT,
        S_DIV_WAIT
    } state_t;

    state_t   state;
    tri_mat_t a_reg;    // Copy of A for the whole run
    pos_t     col;      // Column being factored
    pos_t     row;      // Entry row, equals col on the diagonal
    pos_t     k;        // Product term index
    wide_t    acc;
    wide_t    prod;
    wide_t    term;
    fixed_t   mul_a;
    fixed_t   mul_b;
    fixed_t   residual;
    logic     issue;

    // ========================================================
    // Residual datapath
    // ========================================================

    assign mul_a    = l_out[tri_idx(row, k)];
    assign mul_b    = l_out[tri_idx(col, k)];
    assign prod     = mul_a * mul_b;
    assign term     = prod >>> `CHOL_FRAC;                      // Back to FRAC scale
    assign residual = a_reg[tri_idx(row, col)] - fixed_t'(acc); // Element width wrap

    // All col terms summed, hand the residual to a unit this cycle
    assign issue = (state == S_TERM) && (k == col);

    assign sqrt_bus.start     = issue && (row == col);
    assign sqrt_bus.operand_a = residual;
    assign sqrt_bus.operand_b = '0;
    assign div_bus.start      = issue && (row != col);
    assign div_bus.operand_a  = residual;
    assign div_bus.operand_b  = l_out[tri_idx(col, col)];    // L_jj

    always_ff @(posedge clk) begin
        if ((state == S_IDLE) && a_valid) begin
            a_reg <= a_in;
        end
        if ((state == S_TERM) && !issue) begin
            acc <= acc + term;
        end else begin
            acc <= '0;  // Fresh sum for every entry
        end
    end

    // ========================================================
    // Column and row schedule
    // ========================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= S_IDLE;
            busy    <= 1'b0;
            l_valid <= 1'b0;
            l_out   <= '0;
            col     <= '0;
            row     <= '0;
            k       <= '0;
        end else begin
            l_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (a_valid) begin
                        busy  <= 1'b1;
                        col   <= '0;
                        row   <= '0;
                        k     <= '0;
                        state <= S_TERM;
                    end
                end
                S_TERM: begin
                    if (issue) begin
                        state <= (row == col) ? S_SQRT_WAIT : S_DIV_WAIT;
                    end else begin
                        k <= k + 1'b1;
                    end
                end
                S_SQRT_WAIT: begin
                    if (sqrt_bus.done) begin
                        l_out[tri_idx(col, col)] <= sqrt_bus.result;
                        k <= '0;
                        if (col == pos_t'(`CHOL_N - 1)) begin
                            busy    <= 1'b0;    // Last entry written on this edge
                            l_valid <= 1'b1;
                            state   <= S_IDLE;
                        end else begin
                            row   <= col + 1'b1;
                            state <= S_TERM;
                        end
                    end
                end
                S_DIV_WAIT: begin
                    if (div_bus.done) begin
                        l_out[tri_idx(row, col)] <= div_bus.result;
                        k     <= '0;
                        state <= S_TERM;
                        if (row == pos_t'(`CHOL_N - 1)) begin
                            col <= col + 1'b1;  // Next diagonal
                            row <= col + 1'b1;
                        end else begin
                            row <= row + 1'b1;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Result pulse only closes a run that was in progress
    a_valid_in_run: assert property (@(posedge clk) disable iff (rst)
        l_valid |-> $past(busy))
        else $error("l_valid without a preceding run");

endmodule

// File: hw/cholesky.sv
`timescale 1ns/1ps

module cholesky (
    input  logic                      clk,
    input  logic                      rst,
    input  chol_matrix_pkg::tri_mat_t a_in,
    input  logic                      a_valid,
    output chol_matrix_pkg::tri_mat_t l_out,
    output logic                      l_valid,
    output logic                      busy
);

    chol_arith_if sqrt_bus ();  // Diagonal entries
    chol_arith_if div_bus ();   // Entries below the diagonal

    chol_sequencer sequencer_inst (
        .clk      (clk),
        .rst      (rst),
        .a_in     (a_in),
        .a_valid  (a_valid),
        .l_out    (l_out),
        .l_valid  (l_valid),
        .busy     (busy),
        .sqrt_bus (sqrt_bus.master),
        .div_bus  (div_bus.master)
    );

    chol_sqrt_unit sqrt_inst (
        .clk (clk),
        .rst (rst),
        .bus (sqrt_bus.unit)
    );

    chol_div_unit div_inst (
        .clk (clk),
        .rst (rst),
        .bus (div_bus.unit)
    );

endmodule

// File: testbench/chol_checker.sv
`timescale 1ns/1ps
`include "chol_consts.svh"

module chol_checker (
    input  logic                      clk,
    input  logic                      rst,
    input  chol_matrix_pkg::tri_mat_t a_in,
    input  logic                      a_valid,
    input  logic                      busy,
    input  chol_matrix_pkg::tri_mat_t l_out,
    input  logic                      l_valid,
    input  logic [8*16-1:0]           test_name,
    output int                        errors,
    output int                        results
);

    import chol_fixed_pkg::*;
    import chol_matrix_pkg::*;

    tri_mat_t        exp_q[$];     // Expected L per accepted run, oldest first
    logic [8*16-1:0] name_q[$];
    logic            rst_q;

    function automatic fixed_t prod_fx(input fixed_t x, input fixed_t y);
        wide_t p;
        p = wide_t'(x) * wide_t'(y);
        return fixed_t'(p >>> `CHOL_FRAC);
    endfunction

    // floor(sqrt(x * 2^FRAC)), one root bit tried at a time
    function automatic fixed_t sqrt_fx(input fixed_t x);
        longint v;
        longint r;
        longint t;
        v = longint'(x) <<< `CHOL_FRAC;
        r = 0;
        if (v < 0) return '0;
        for (int b = `CHOL_SQRT_ITER - 1; b >= 0; b--) begin
            t = r + (longint'(1) << b);
            if (t * t <= v) r = t;
        end
        return fixed_t'(r);
    endfunction

    function automatic fixed_t div_fx(input fixed_t x, input fixed_t y);
        longint n;
        n = longint'(x) <<< `CHOL_FRAC;
        if (y == '0) return '0;
        return fixed_t'(n / longint'(y));     // SV division truncates toward zero
    endfunction

    // Column by column, entries 11, 21, 22, 31, 32, 33
    function automatic tri_mat_t reference_l(input tri_mat_t a);
        tri_mat_t l;
        l    = '0;
        l[0] = sqrt_fx(a[0]);
        l[1] = div_fx(a[1], l[0]);
        l[3] = div_fx(a[3], l[0]);
        l[2] = sqrt_fx(a[2] - prod_fx(l[1], l[1]));
        l[4] = div_fx(a[4] - prod_fx(l[3], l[1]), l[2]);
        l[5] = sqrt_fx(a[5] - prod_fx(l[3], l[3]) - prod_fx(l[4], l[4]));
        return l;
    endfunction

    initial begin
        errors  = 0;
        results = 0;
    end

    always @(posedge clk) begin : compare
        tri_mat_t        exp_l;
        logic [8*16-1:0] name;
        rst_q <= rst;
        if (rst_q && !rst && (busy || l_valid || l_out != '0)) begin  // First edge out of reset
            $display("FAIL reset: expected idle outputs, busy %0b l_valid %0b l_out %h",
                     busy, l_valid, l_out);
            errors++;
        end
        if (!rst && l_valid) begin
            results++;
            if (exp_q.size() == 0) begin
                $display("l_valid pulsed with no matrix accepted before it");
                errors++;
            end else begin
                exp_l = exp_q.pop_front();
                name  = name_q.pop_front();
                for (int i = 0; i < `CHOL_ENTRIES; i++) begin
                    if (l_out[i] !== exp_l[i]) begin
                        $display("FAIL %0s entry %0d expected %0d actual %0d",
                                 name, i, exp_l[i], l_out[i]);
                        errors++;
                    end
                end
            end
        end
        if (!rst && a_valid && !busy) begin   // Run accepted on this edge
            exp_q.push_back(reference_l(a_in));
            name_q.push_back(test_name);
        end
    end

endmodule

// File: testbench/tb_cholesky.sv
`timescale 1ns/1ps
`include "chol_consts.svh"

module tb_cholesky;

    import chol_matrix_pkg::*;

    localparam int     NUM_RANDOM  = 50;
    localparam int     NUM_RUNS    = NUM_RANDOM + 4;   // Plus identity, busy drop, two back to back
    localparam int     RUN_CYCLES  = 3 * (`CHOL_SQRT_ITER + 2) + 3 * (`CHOL_DIV_ITER + 2) + 20;
    localparam longint WATCHDOG_NS = longint'(NUM_RUNS) * RUN_CYCLES * 40 * 2;
    localparam int     ONE         = 1 << `CHOL_FRAC;

    logic            clk;
    logic            rst;
    tri_mat_t        a_in;
    logic            a_valid;
    tri_mat_t        l_out;
    logic            l_valid;
    logic            busy;
    logic [8*16-1:0] test_name;
    int              tb_errors;
    int              chk_errors;
    int              results;
    int              runs_applied;
    int              seed_ret;
    logic            extra;
    tri_mat_t        m_first;
    tri_mat_t        m_second;

    cholesky cholesky_inst (.clk(clk), .rst(rst), .a_in(a_in), .a_valid(a_valid),
                            .l_out(l_out), .l_valid(l_valid), .busy(busy));

    chol_checker checker_inst (.clk(clk), .rst(rst), .a_in(a_in), .a_valid(a_valid),
                               .busy(busy), .l_out(l_out), .l_valid(l_valid),
                               .test_name(test_name), .errors(chk_errors), .results(results));

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // ========================================================
    // Stimulus helpers
    // ========================================================

    function automatic logic signed [`CHOL_W-1:0] fx_mul(input logic signed [`CHOL_W-1:0] x,
                                                         input logic signed [`CHOL_W-1:0] y);
        logic signed [2*`CHOL_W-1:0] p;
        p = x * y;
        return p >>> `CHOL_FRAC;
    endfunction

    // A = M * M^T, M lower with diagonal in [1, 4] and the rest in [-1, 1]
    function automatic tri_mat_t random_spd();
        logic signed [`CHOL_W-1:0] m [`CHOL_ENTRIES];
        tri_mat_t a;
        for (int i = 0; i < `CHOL_ENTRIES; i++) begin
            if (i == 0 || i == 2 || i == 5) m[i] = ONE + ($urandom % (3 * ONE + 1));
            else m[i] = ($urandom % (2 * ONE + 1)) - ONE;
        end
        a[0] = fx_mul(m[0], m[0]);
        a[1] = fx_mul(m[1], m[0]);
        a[2] = fx_mul(m[1], m[1]) + fx_mul(m[2], m[2]);
        a[3] = fx_mul(m[3], m[0]);
        a[4] = fx_mul(m[3], m[1]) + fx_mul(m[4], m[2]);
        a[5] = fx_mul(m[3], m[3]) + fx_mul(m[4], m[4]) + fx_mul(m[5], m[5]);
        return a;
    endfunction

    // Caller is at a falling edge
    task automatic apply_matrix(input logic [8*16-1:0] name, input tri_mat_t m);
        test_name = name;
        a_in      = m;
        a_valid   = 1'b1;
        runs_applied++;
        @(negedge clk);
        a_valid   = 1'b0;
    endtask

    // Returns on the falling edge where l_valid is high
    task automatic wait_done();
        int n;
        n = 0;
        @(negedge clk);
        while (!l_valid && n < 2 * RUN_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (!l_valid) begin
            $display("Timeout: l_valid never came for test %0s", test_name);
            tb_errors++;
        end
    endtask

    // ========================================================
    // Test sequence
    // ========================================================

    initial begin
        rst          = 1'b1;
        a_valid      = 1'b0;
        a_in         = '0;
        test_name    = "reset";
        tb_errors    = 0;
        runs_applied = 0;
        extra        = 1'b0;
        seed_ret     = $urandom(32'h00f7_3036);
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Entries 33, 32, 31, 22, 21, 11 from the left
        @(negedge clk);
        apply_matrix("identity", {4 * ONE, 32'sd0, 32'sd0, 4 * ONE, 32'sd0, 4 * ONE});
        wait_done();

        for (int t = 0; t < NUM_RANDOM; t++) begin
            @(negedge clk);
            apply_matrix("random", random_spd());
            wait_done();
        end

        m_first  = random_spd();
        m_second = random_spd();
        @(negedge clk);
        apply_matrix("busy_drop", m_first);
        repeat (4) @(negedge clk);
        if (!busy) begin
            $display("DUT was not busy when the extra a_valid was driven");
            tb_errors++;
        end
        a_in    = m_second;
        a_valid = 1'b1;        // Must be dropped
        @(negedge clk);
        a_valid = 1'b0;
        wait_done();
        repeat (RUN_CYCLES) begin
            @(negedge clk);
            if (l_valid || busy) extra = 1'b1;
        end
        if (extra) begin
            $display("A run started from an a_valid that came while busy");
            tb_errors++;
        end

        @(negedge clk);
        apply_matrix("back_to_back_1", random_spd());
        wait_done();
        apply_matrix("back_to_back_2", random_spd());  // Same cycle busy falls
        wait_done();

        @(posedge clk);
        @(negedge clk);
        if (results != runs_applied) begin
            $display("Expected %0d results from the DUT, saw %0d", runs_applied, results);
            tb_errors++;
        end
        $display("Errors: %0d (checker %0d, testbench %0d), results %0d",
                 chk_errors + tb_errors, chk_errors, tb_errors, results);
        if (chk_errors + tb_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, errors so far %0d",
                 WATCHDOG_NS, chk_errors + tb_errors);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+hw
hw/chol_fixed_pkg.sv
hw/chol_matrix_pkg.sv
hw/chol_arith_if.sv
hw/chol_sqrt_unit.sv
hw/chol_div_unit.sv
hw/chol_sequencer.sv
hw/cholesky.sv
testbench/chol_checker.sv
testbench/tb_cholesky.sv
